// File: hw/riscv_pkg.sv
package riscv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       addr_t;
  typedef logic [xlen-1:0]       data_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_imm    = 7'b0010011,
    op_op     = 7'b0110011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011
  } opcode_t;

  // instruction formats, all views of the same word
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    opcode_t     opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
  } instr_u;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_t;

  typedef enum logic [1:0] {
    fwd_none,
    fwd_from_mem,
    fwd_from_wb
  } fwd_sel_t;

  typedef struct packed {
    addr_t  pc;
    instr_u instr;
  } if_to_id_t;

  typedef struct packed {
    addr_t    pc;
    data_t    rs1_val;
    data_t    rs2_val;
    data_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    alu_op_t  alu_op;
    logic     alu_src_imm;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     branch;
    logic     branch_ne;
  } id_to_ex_t;

  typedef struct packed {
    data_t    alu_result;
    data_t    store_data;
    reg_idx_t rd;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
  } ex_to_mem_t;

  typedef struct packed {
    data_t    alu_result;
    data_t    load_data;
    reg_idx_t rd;
    logic     reg_write;
    logic     mem_read;
  } mem_to_wb_t;

  typedef struct packed {
    logic  branch_taken;
    addr_t pc_target;
  } ex_to_if_t;

endpackage

// File: hw/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage import riscv_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      stall,
  input  ex_to_if_t from_ex,
  output addr_t     imem_address,
  input  data_t     imem_data,
  output if_to_id_t to_id
);

  addr_t pc;
  addr_t pc_next;

  // taken branch wins over sequential fetch
  assign pc_next = from_ex.branch_taken ? from_ex.pc_target : pc + addr_t'(4);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= pc_next;
    end
  end

  assign imem_address = pc;

  // instruction word comes back in the same cycle
  assign to_id.pc    = pc;
  assign to_id.instr = imem_data;

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/10ps

module decode_stage import riscv_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  if_to_id_t  from_if,
  input  mem_to_wb_t from_wb,
  output data_t      wb_result,
  output id_to_ex_t  to_ex
);

  data_t  regs [1:31];
  instr_u instr;
  logic   wb_write;
  data_t  imm_i;
  data_t  imm_s;
  data_t  imm_b;
  data_t  imm_u;

  function automatic alu_op_t alu_from_funct3(logic [2:0] funct3, logic sub);
    case (funct3)
      3'b000:  return sub ? alu_sub : alu_add;
      3'b010:  return alu_slt;
      3'b100:  return alu_xor;
      3'b110:  return alu_or;
      3'b111:  return alu_and;
      default: return alu_add;
    endcase
  endfunction

  // x0 reads zero, a same-cycle writeback is seen immediately
  function automatic data_t read_reg(reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (wb_write && from_wb.rd == idx) begin
      return wb_result;
    end
    return regs[idx];
  endfunction

  assign wb_result = from_wb.mem_read ? from_wb.load_data : from_wb.alu_result;
  assign wb_write  = from_wb.reg_write && from_wb.rd != '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_write) begin
      regs[from_wb.rd] <= wb_result;
    end
  end

  assign instr = from_if.instr;

  // sign-extended immediates per format
  assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
  assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                  instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
  assign imm_u = {instr.u.imm, 12'b0};

  always_comb begin
    to_ex         = '0;
    to_ex.pc      = from_if.pc;
    to_ex.rs1     = instr.r.rs1;
    to_ex.rs2     = instr.r.rs2;
    to_ex.rs1_val = read_reg(instr.r.rs1);
    to_ex.rs2_val = read_reg(instr.r.rs2);
    // an all-zero word falls to default and becomes a bubble
    case (instr.r.opcode)
      op_lui: begin
        to_ex.imm         = imm_u;
        to_ex.rd          = instr.u.rd;
        to_ex.alu_op      = alu_pass_b;
        to_ex.alu_src_imm = 1'b1;
        to_ex.reg_write   = 1'b1;
      end
      op_imm: begin
        to_ex.imm         = imm_i;
        to_ex.rd          = instr.i.rd;
        to_ex.alu_op      = alu_from_funct3(instr.i.funct3, 1'b0);
        to_ex.alu_src_imm = 1'b1;
        to_ex.reg_write   = 1'b1;
      end
      op_op: begin
        to_ex.rd        = instr.r.rd;
        to_ex.alu_op    = alu_from_funct3(instr.r.funct3, instr.r.funct7[5]);
        to_ex.reg_write = 1'b1;
      end
      op_load: begin
        to_ex.imm         = imm_i;
        to_ex.rd          = instr.i.rd;
        to_ex.alu_src_imm = 1'b1;
        to_ex.reg_write   = 1'b1;
        to_ex.mem_read    = 1'b1;
      end
      op_store: begin
        to_ex.imm         = imm_s;
        to_ex.alu_src_imm = 1'b1;
        to_ex.mem_write   = 1'b1;
      end
      op_branch: begin
        to_ex.imm       = imm_b;
        to_ex.branch    = 1'b1;
        // funct3 bit 0 separates bne from beq
        to_ex.branch_ne = instr.b.funct3[0];
      end
      default: begin
        to_ex.rd = '0;
      end
    endcase
  end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/10ps

module execute_stage import riscv_pkg::*; (
  input  id_to_ex_t  from_id,
  input  fwd_sel_t   fwd_a,
  input  fwd_sel_t   fwd_b,
  input  data_t      mem_result,
  input  data_t      wb_result,
  output ex_to_mem_t to_mem,
  output ex_to_if_t  to_if
);

  data_t src_a;
  data_t rs2_fwd;
  data_t src_b;
  data_t alu_result;
  logic  equal;

  function automatic data_t fwd_mux(fwd_sel_t sel, data_t reg_val, data_t mem_val,
                                    data_t wb_val);
    case (sel)
      fwd_from_mem: return mem_val;
      fwd_from_wb:  return wb_val;
      default:      return reg_val;
    endcase
  endfunction

  assign src_a   = fwd_mux(fwd_a, from_id.rs1_val, mem_result, wb_result);
  assign rs2_fwd = fwd_mux(fwd_b, from_id.rs2_val, mem_result, wb_result);
  assign src_b   = from_id.alu_src_imm ? from_id.imm : rs2_fwd;

  always_comb begin
    case (from_id.alu_op)
      alu_add:    alu_result = src_a + src_b;
      alu_sub:    alu_result = src_a - src_b;
      alu_and:    alu_result = src_a & src_b;
      alu_or:     alu_result = src_a | src_b;
      alu_xor:    alu_result = src_a ^ src_b;
      alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(src_a) < $signed(src_b)};
      alu_pass_b: alu_result = src_b;
      default:    alu_result = '0;
    endcase
  end

  // beq/bne compare the forwarded registers, not the alu operand b
  assign equal = src_a == rs2_fwd;

  assign to_if.branch_taken = from_id.branch && (equal ^ from_id.branch_ne);
  assign to_if.pc_target    = from_id.pc + from_id.imm;

  assign to_mem.alu_result = alu_result;
  assign to_mem.store_data = rs2_fwd;
  assign to_mem.rd         = from_id.rd;
  assign to_mem.reg_write  = from_id.reg_write;
  assign to_mem.mem_read   = from_id.mem_read;
  assign to_mem.mem_write  = from_id.mem_write;

endmodule

// File: hw/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit import riscv_pkg::*; (
  input  reg_idx_t   rs1_d,
  input  reg_idx_t   rs2_d,
  input  id_to_ex_t  ex,
  input  ex_to_mem_t mem,
  input  mem_to_wb_t wb,
  input  logic       branch_taken,
  output fwd_sel_t   fwd_a,
  output fwd_sel_t   fwd_b,
  output logic       stall_f,
  output logic       stall_d,
  output logic       flush_d,
  output logic       flush_e
);

  logic load_use;

  // newest producer first
  function automatic fwd_sel_t fwd_for(reg_idx_t rs, ex_to_mem_t m, mem_to_wb_t w);
    if (rs != '0 && m.reg_write && m.rd == rs) begin
      return fwd_from_mem;
    end
    if (rs != '0 && w.reg_write && w.rd == rs) begin
      return fwd_from_wb;
    end
    return fwd_none;
  endfunction

  assign fwd_a = fwd_for(ex.rs1, mem, wb);
  assign fwd_b = fwd_for(ex.rs2, mem, wb);

  // load result not ready until writeback, hold one cycle
  assign load_use = ex.mem_read && ex.rd != '0 && (ex.rd == rs1_d || ex.rd == rs2_d);

  assign stall_f = load_use;
  assign stall_d = load_use;
  // the two younger instructions are on the wrong path
  assign flush_d = branch_taken;
  assign flush_e = load_use || branch_taken;

endmodule

// File: hw/riscv_pipelined.sv
`timescale 1ns/10ps

module riscv_pipelined import riscv_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  output addr_t      memory_instr_address,
  output data_t      memory_instr_write_data,
  output logic [3:0] memory_instr_write_enable,
  input  data_t      memory_instr_read_data,
  output addr_t      memory_data_address,
  output data_t      memory_data_write_data,
  output logic [3:0] memory_data_write_enable,
  input  data_t      memory_data_read_data
);

  if_to_id_t  if_to_id_out;
  if_to_id_t  if_to_id_reg;
  id_to_ex_t  id_to_ex_out;
  id_to_ex_t  id_to_ex_reg;
  ex_to_mem_t ex_to_mem_out;
  ex_to_mem_t ex_to_mem_reg;
  mem_to_wb_t mem_to_wb_out;
  mem_to_wb_t mem_to_wb_reg;
  ex_to_if_t  ex_to_if_out;
  data_t      wb_result;
  fwd_sel_t   fwd_a;
  fwd_sel_t   fwd_b;
  logic       stall_f;
  logic       stall_d;
  logic       flush_d;
  logic       flush_e;

  fetch_stage u_fetch (
    .clk          (clk),
    .reset        (reset),
    .stall        (stall_f),
    .from_ex      (ex_to_if_out),
    .imem_address (memory_instr_address),
    .imem_data    (memory_instr_read_data),
    .to_id        (if_to_id_out)
  );

  // instruction port is read only
  assign memory_instr_write_data   = '0;
  assign memory_instr_write_enable = 4'b0000;

  // flush takes priority, a zero word decodes as a bubble
  always_ff @(posedge clk) begin
    if (reset || flush_d) begin
      if_to_id_reg <= '0;
    end else if (!stall_d) begin
      if_to_id_reg <= if_to_id_out;
    end
  end

  decode_stage u_decode (
    .clk       (clk),
    .reset     (reset),
    .from_if   (if_to_id_reg),
    .from_wb   (mem_to_wb_reg),
    .wb_result (wb_result),
    .to_ex     (id_to_ex_out)
  );

  always_ff @(posedge clk) begin
    if (reset || flush_e) begin
      id_to_ex_reg <= '0;
    end else begin
      id_to_ex_reg <= id_to_ex_out;
    end
  end

  execute_stage u_execute (
    .from_id    (id_to_ex_reg),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .mem_result (ex_to_mem_reg.alu_result),
    .wb_result  (wb_result),
    .to_mem     (ex_to_mem_out),
    .to_if      (ex_to_if_out)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_to_mem_reg <= '0;
    end else begin
      ex_to_mem_reg <= ex_to_mem_out;
    end
  end

  // memory stage, word accesses only
  assign memory_data_address      = ex_to_mem_reg.alu_result;
  assign memory_data_write_data   = ex_to_mem_reg.store_data;
  assign memory_data_write_enable = ex_to_mem_reg.mem_write ? 4'b1111 : 4'b0000;

  always_comb begin
    mem_to_wb_out.alu_result = ex_to_mem_reg.alu_result;
    mem_to_wb_out.load_data  = memory_data_read_data;
    mem_to_wb_out.rd         = ex_to_mem_reg.rd;
    mem_to_wb_out.reg_write  = ex_to_mem_reg.reg_write;
    mem_to_wb_out.mem_read   = ex_to_mem_reg.mem_read;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_to_wb_reg <= '0;
    end else begin
      mem_to_wb_reg <= mem_to_wb_out;
    end
  end

  hazard_unit u_hazard (
    .rs1_d        (if_to_id_reg.instr.r.rs1),
    .rs2_d        (if_to_id_reg.instr.r.rs2),
    .ex           (id_to_ex_reg),
    .mem          (ex_to_mem_reg),
    .wb           (mem_to_wb_reg),
    .branch_taken (ex_to_if_out.branch_taken),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b),
    .stall_f      (stall_f),
    .stall_d      (stall_d),
    .flush_d      (flush_d),
    .flush_e      (flush_e)
  );

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
  output logic clk,
  output logic reset
);

  // 40 ns period
  initial clk = 1'b0;
  always #20 clk = ~clk;

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: bench/riscv_sva.sv
`timescale 1ns/10ps

module riscv_sva import riscv_pkg::*; (
  input logic       clk,
  input logic       reset,
  input addr_t      memory_instr_address,
  input logic [3:0] memory_instr_write_enable,
  input logic [3:0] memory_data_write_enable
);

  // word stores only
  a_data_we_whole: assert property (@(posedge clk) disable iff (reset)
    memory_data_write_enable == 4'h0 || memory_data_write_enable == 4'hf)
    else $error("data write enable is a partial word");

  a_instr_we_zero: assert property (@(posedge clk) memory_instr_write_enable == 4'h0)
    else $error("instruction port was written");

  a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
    memory_instr_address[1:0] == 2'b00)
    else $error("fetch address is not word aligned");

  // first cycle out of reset has empty pipeline registers
  a_no_store_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> memory_data_write_enable == 4'h0)
    else $error("data write in the first cycle after reset");

endmodule

bind riscv_pipelined riscv_sva u_sva (
  .clk                       (clk),
  .reset                     (reset),
  .memory_instr_address      (memory_instr_address),
  .memory_instr_write_enable (memory_instr_write_enable),
  .memory_data_write_enable  (memory_data_write_enable)
);

// File: bench/tb_riscv.sv
`timescale 1ns/10ps

module tb_riscv import riscv_pkg::*; ();

  localparam int prog_len = 200;
  localparam int loop_idx = prog_len + 7;
  localparam addr_t loop_pc = addr_t'(loop_idx * 4);
  localparam int timeout_cycles = 3000;

  logic       clk;
  logic       reset;
  addr_t      iaddr;
  data_t      iwdata;
  logic [3:0] iwe;
  data_t      irdata;
  addr_t      daddr;
  data_t      dwdata;
  logic [3:0] dwe;
  data_t      drdata;

  data_t  imem [0:255];
  data_t  dmem [0:255];
  data_t  model_mem [0:255];
  data_t  exp_addr [$];
  data_t  exp_data [$];
  integer seed = 32'hfa58_62fb;
  int     errors = 0;
  int     store_idx = 0;

  clock_gen u_clock (
    .clk   (clk),
    .reset (reset)
  );

  riscv_pipelined UUT (
    .clk                       (clk),
    .reset                     (reset),
    .memory_instr_address      (iaddr),
    .memory_instr_write_data   (iwdata),
    .memory_instr_write_enable (iwe),
    .memory_instr_read_data    (irdata),
    .memory_data_address       (daddr),
    .memory_data_write_data    (dwdata),
    .memory_data_write_enable  (dwe),
    .memory_data_read_data     (drdata)
  );

  // both memories answer in the same cycle
  assign irdata = imem[iaddr[9:2]];
  assign drdata = dmem[daddr[9:2]];

  always @(posedge clk) begin
    if (dwe == 4'hf) begin
      dmem[daddr[9:2]] <= dwdata;
    end
  end

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // destination and source registers stay within x1..x7
  function automatic reg_idx_t pick_reg();
    logic [31:0] r;
    r = rand_word();
    return reg_idx_t'(r % 32'd7 + 32'd1);
  endfunction

  // sel 1 is the sub slot for r-type
  function automatic logic [2:0] funct3_for(int sel);
    case (sel)
      0, 1:    return 3'b000;
      2:       return 3'b010;
      3:       return 3'b100;
      4:       return 3'b110;
      default: return 3'b111;
    endcase
  endfunction

  function automatic data_t alu_ref(logic [2:0] f3, logic sub, data_t a, data_t b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic gen_program();
    instr_u      w;
    logic [31:0] r;
    logic [11:0] off;
    logic [12:0] boff;
    int          kind;
    int          sel;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
      dmem[i] = (32'h9e37_79b9 * (i + 1)) ^ {24'h5a5a5a, 8'(i)};
      model_mem[i] = dmem[i];
    end
    for (int i = 0; i < prog_len; i++) begin
      w = '0;
      r = rand_word();
      kind = int'(r % 32'd10);
      sel = int'(r[15:8] % 8'd6);
      // keep branch targets inside the random body
      if (kind == 9 && i > prog_len - 5) begin
        kind = 0;
      end
      case (kind)
        0, 1, 2, 3: begin
          w.r.opcode = op_op;
          w.r.rd = pick_reg();
          w.r.rs1 = pick_reg();
          w.r.rs2 = pick_reg();
          w.r.funct3 = funct3_for(sel);
          w.r.funct7 = (sel == 1) ? 7'b0100000 : 7'b0000000;
        end
        4, 5: begin
          w.i.opcode = op_imm;
          w.i.rd = pick_reg();
          w.i.rs1 = pick_reg();
          w.i.funct3 = funct3_for(sel);
          w.i.imm = r[27:16];
        end
        6: begin
          w.u.opcode = op_lui;
          w.u.rd = pick_reg();
          r = rand_word();
          w.u.imm = r[19:0];
        end
        7: begin
          w.i.opcode = op_load;
          w.i.funct3 = 3'b010;
          w.i.rd = pick_reg();
          w.i.imm = {5'b0, r[20:16], 2'b00};
        end
        8: begin
          off = {5'b0, r[20:16], 2'b00};
          w.s.opcode = op_store;
          w.s.funct3 = 3'b010;
          w.s.rs2 = pick_reg();
          w.s.imm_11_5 = off[11:5];
          w.s.imm_4_0 = off[4:0];
        end
        default: begin
          boff = 13'(4 * (2 + int'(r[31:28] % 4'd3)));
          w.b.opcode = op_branch;
          w.b.funct3 = r[24] ? 3'b001 : 3'b000;
          w.b.rs1 = pick_reg();
          w.b.rs2 = r[25] ? w.b.rs1 : pick_reg();
          w.b.imm_12 = boff[12];
          w.b.imm_11 = boff[11];
          w.b.imm_10_5 = boff[10:5];
          w.b.imm_4_1 = boff[4:1];
        end
      endcase
      imem[i] = w;
    end
    // dump x1..x7 above the random data region
    for (int k = 1; k <= 7; k++) begin
      w = '0;
      off = 12'(32'h200 + 4 * (k - 1));
      w.s.opcode = op_store;
      w.s.funct3 = 3'b010;
      w.s.rs2 = reg_idx_t'(k);
      w.s.imm_11_5 = off[11:5];
      w.s.imm_4_0 = off[4:0];
      imem[prog_len + k - 1] = w;
    end
    // beq x0, x0, 0
    w = '0;
    w.b.opcode = op_branch;
    imem[loop_idx] = w;
  endtask

  // in-order reference model that records every store
  task automatic run_model();
    data_t  x [0:31];
    instr_u w;
    addr_t  pc;
    addr_t  ea;
    data_t  imm;
    int     steps;
    for (int i = 0; i < 32; i++) begin
      x[i] = '0;
    end
    pc = '0;
    steps = 0;
    while (pc != loop_pc && steps < 2000) begin
      w = imem[pc[9:2]];
      pc = pc + 32'd4;
      case (w.r.opcode)
        op_lui: x[w.u.rd] = {w.u.imm, 12'h000};
        op_imm: begin
          imm = {{20{w.i.imm[11]}}, w.i.imm};
          x[w.i.rd] = alu_ref(w.i.funct3, 1'b0, x[w.i.rs1], imm);
        end
        op_op: x[w.r.rd] = alu_ref(w.r.funct3, w.r.funct7[5], x[w.r.rs1], x[w.r.rs2]);
        op_load: begin
          ea = x[w.i.rs1] + {{20{w.i.imm[11]}}, w.i.imm};
          x[w.i.rd] = model_mem[ea[9:2]];
        end
        op_store: begin
          ea = x[w.s.rs1] + {{20{w.s.imm_11_5[6]}}, w.s.imm_11_5, w.s.imm_4_0};
          model_mem[ea[9:2]] = x[w.s.rs2];
          exp_addr.push_back(ea);
          exp_data.push_back(x[w.s.rs2]);
        end
        op_branch: begin
          imm = {{19{w.b.imm_12}}, w.b.imm_12, w.b.imm_11, w.b.imm_10_5, w.b.imm_4_1, 1'b0};
          if ((x[w.b.rs1] == x[w.b.rs2]) != w.b.funct3[0]) begin
            pc = pc - 32'd4 + imm;
          end
        end
        default: ;
      endcase
      x[0] = '0;
      steps++;
    end
  endtask

  // data port is stable away from the rising edge
  always @(negedge clk) begin
    if (reset === 1'b0 && dwe != 4'h0) begin
      if (store_idx < exp_addr.size()) begin
        check_value("memory_data_address", daddr, exp_addr[store_idx]);
        check_value("memory_data_write_data", dwdata, exp_data[store_idx]);
      end else begin
        $display("store to address %h that the model never makes", daddr);
        errors++;
      end
      store_idx++;
    end
  end

  // instruction port never carries write data
  always @(negedge clk) begin
    if (reset === 1'b0) begin
      check_value("memory_instr_write_data", iwdata, 32'h0);
    end
  end

  initial begin
    int cycles;
    gen_program();
    run_model();
    cycles = 0;
    while (reset !== 1'b0 && cycles < 10) begin
      @(posedge clk);
      cycles++;
    end
    if (reset !== 1'b0) begin
      $display("reset was never released");
      errors++;
    end else begin
      cycles = 0;
      while (!(store_idx >= exp_addr.size() && iaddr == loop_pc) &&
             cycles < timeout_cycles) begin
        @(posedge clk);
        cycles++;
      end
      if (cycles >= timeout_cycles) begin
        $display("core did not reach the final loop within %0d cycles", timeout_cycles);
        errors++;
      end else begin
        check_value("store_count", store_idx, exp_addr.size());
      end
    end
    $display("stores seen %0d, stores expected %0d, errors %0d",
             store_idx, exp_addr.size(), errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: build.f
hw/riscv_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/hazard_unit.sv
hw/riscv_pipelined.sv
bench/clock_gen.sv
bench/riscv_sva.sv
bench/tb_riscv.sv

// File: Makefile
TOOL     := verilator
TOP      := tb_riscv
FILELIST := build.f
FLAGS    := --binary --timing --assert --timescale 1ns/10ps
BUILD    := obj_dir
LOG      := sim.log
PASS     := STATUS: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with $(TOOL) and run it"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
